/* project.f */
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_lsu.sv
hw/rv_wbu.sv
hw/rv_core.sv
tests/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide on the log contents
rm -rf build sim.log
verilator --binary --timing --top-module tb_rv_core -Mdir build -o sim -f project.f || exit 1
./build/sim > sim.log 2>&1
cat sim.log
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

/* tests/tb_rv_core.sv */
// program is assembled at time zero; loads read only words 0..3, stores start at 0x40
`include "rv_core_macros.svh"

module tb_rv_core;

	logic clk;
	logic rst_n;
	rv_core_pkg::word_t inst;
	rv_core_pkg::word_t dmem_rdata;
	rv_core_pkg::word_t pc;
	rv_core_pkg::mem_req_t dmem_req;
	logic halted;

	rv_core_pkg::word_t imem [256];
	rv_core_pkg::word_t dmem [128];
	rv_core_pkg::word_t load_ref [4];
	rv_core_pkg::word_t exp_addr [$];
	rv_core_pkg::word_t exp_data [$];
	rv_core_pkg::strb_t exp_strb [$];
	int prog_len;
	int store_idx;
	rv_core_pkg::word_t st_addr;
	logic built;

	rv_core uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.dmem_rdata (dmem_rdata),
		.pc         (pc),
		.dmem_req   (dmem_req),
		.halted     (halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// both memories read asynchronously
	assign inst = imem[pc[9:2]];
	assign dmem_rdata = dmem[dmem_req.addr[8:2]];

	always @(posedge clk) begin
		if (dmem_req.wen) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_req.wstrb[b]) begin
					dmem[dmem_req.addr[8:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
				end
			end
		end
	end

	function automatic rv_core_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
	endfunction

	function automatic rv_core_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic rv_core_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
	endfunction

	function automatic rv_core_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
	endfunction

	function automatic rv_core_pkg::word_t cur_pc();
		return rv_core_pkg::word_t'(prog_len) << 2;
	endfunction

	task automatic emit(input rv_core_pkg::word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_store(input rv_core_pkg::word_t addr, input rv_core_pkg::word_t data,
		input rv_core_pkg::strb_t strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	// sw of a register to the next free result word
	task automatic store_word(input logic [4:0] rs, input rv_core_pkg::word_t value);
		emit(enc_s(st_addr[11:0], rs, 5'd0, 3'b010));
		expect_store(st_addr, value, 4'hf);
		st_addr += 4;
	endtask

	task automatic alu_i(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
		input rv_core_pkg::word_t value);
		emit(enc_i(imm, rs1, f3, 5'd3, `RV_OPC_OP_IMM));
		store_word(5'd3, value);
	endtask

	task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input rv_core_pkg::word_t value);
		emit(enc_r(f7, rs2, rs1, f3, 5'd3));
		store_word(5'd3, value);
	endtask

	// a taken branch skips the marker store right behind it
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic taken);
		emit(enc_b(13'd8, rs2, rs1, f3));
		emit(enc_s(st_addr[11:0], 5'd6, 5'd0, 3'b010));
		if (!taken) begin
			expect_store(st_addr, 32'h0000_005a, 4'hf);
		end
		st_addr += 4;
	endtask

	task automatic check_value(input string name, input rv_core_pkg::word_t exp,
		input rv_core_pkg::word_t act);
		assert (exp === act) else begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_store();
		rv_core_pkg::word_t mask;
		assert (store_idx < exp_addr.size()) else begin
			$display("store to %h with no store left to expect", dmem_req.addr);
			$display("TESTS FAILED");
			$fatal(1);
		end
		for (int b = 0; b < 4; b++) begin
			mask[8*b +: 8] = {8{exp_strb[store_idx][b]}};
		end
		check_value($sformatf("store %0d addr", store_idx), exp_addr[store_idx], dmem_req.addr);
		check_value($sformatf("store %0d strb", store_idx), 32'(exp_strb[store_idx]),
			32'(dmem_req.wstrb));
		check_value($sformatf("store %0d data", store_idx), exp_data[store_idx] & mask,
			dmem_req.wdata & mask);
		store_idx++;
	endtask

	task automatic build_program();
		rv_core_pkg::word_t p;
		// first word retires before the first sample
		emit(32'h0000_0013);
		emit(enc_i(12'hff9, 5'd0, 3'b000, 5'd1, `RV_OPC_OP_IMM));
		store_word(5'd1, 32'hffff_fff9);
		emit(enc_i(12'd100, 5'd0, 3'b000, 5'd2, `RV_OPC_OP_IMM));
		emit(enc_i(12'h05a, 5'd0, 3'b000, 5'd6, `RV_OPC_OP_IMM));
		alu_i(3'b010, 12'd1, 5'd1, 32'd1);
		alu_i(3'b011, 12'd1, 5'd1, 32'd0);
		alu_i(3'b111, 12'h0f0, 5'd2, 32'h60);
		alu_i(3'b110, 12'h703, 5'd2, 32'h767);
		alu_i(3'b100, 12'hfff, 5'd1, 32'd6);
		alu_i(3'b001, 12'd4, 5'd2, 32'h640);
		alu_i(3'b101, 12'd28, 5'd1, 32'hf);
		alu_i(3'b101, 12'h401, 5'd1, 32'hffff_fffc);
		alu_r(7'h00, 3'b000, 5'd1, 5'd2, 32'h5d);
		alu_r(7'h20, 3'b000, 5'd2, 5'd1, 32'h6b);
		alu_r(7'h00, 3'b010, 5'd1, 5'd2, 32'd1);
		alu_r(7'h00, 3'b011, 5'd1, 5'd2, 32'd0);
		alu_r(7'h00, 3'b111, 5'd1, 5'd2, 32'h60);
		alu_r(7'h00, 3'b110, 5'd1, 5'd2, 32'hffff_fffd);
		alu_r(7'h00, 3'b100, 5'd1, 5'd2, 32'hffff_ff9d);
		alu_r(7'h00, 3'b001, 5'd1, 5'd2, 32'hffff_ff90);
		alu_r(7'h00, 3'b101, 5'd1, 5'd2, 32'h0fff_ffff);
		alu_r(7'h20, 3'b101, 5'd1, 5'd2, 32'hffff_ffff);
		emit({20'h12345, 5'd3, `RV_OPC_LUI});
		store_word(5'd3, 32'h1234_5000);
		p = cur_pc();
		emit({20'h00001, 5'd3, `RV_OPC_AUIPC});
		store_word(5'd3, p + 32'h1000);
		// x4 = 0x89abcdef for the sub-word stores
		emit({20'h89abd, 5'd4, `RV_OPC_LUI});
		emit(enc_i(12'hdef, 5'd4, 3'b000, 5'd4, `RV_OPC_OP_IMM));
		for (int k = 0; k < 4; k++) begin
			emit(enc_s(st_addr[11:0] + 12'(k), 5'd4, 5'd0, 3'b000));
			expect_store(st_addr, 32'h89ab_cdef << (8 * k), 4'b0001 << k);
			st_addr += 4;
		end
		for (int k = 0; k < 4; k += 2) begin
			emit(enc_s(st_addr[11:0] + 12'(k), 5'd4, 5'd0, 3'b001));
			expect_store(st_addr, 32'h89ab_cdef << (8 * k), 4'b0011 << k);
			st_addr += 4;
		end
		emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, `RV_OPC_LOAD));
		store_word(5'd5, {{24{load_ref[0][15]}}, load_ref[0][15:8]});
		emit(enc_i(12'd3, 5'd0, 3'b100, 5'd5, `RV_OPC_LOAD));
		store_word(5'd5, {24'h0, load_ref[0][31:24]});
		emit(enc_i(12'd6, 5'd0, 3'b001, 5'd5, `RV_OPC_LOAD));
		store_word(5'd5, {{16{load_ref[1][31]}}, load_ref[1][31:16]});
		emit(enc_i(12'd8, 5'd0, 3'b101, 5'd5, `RV_OPC_LOAD));
		store_word(5'd5, {16'h0, load_ref[2][15:0]});
		emit(enc_i(12'd12, 5'd0, 3'b010, 5'd5, `RV_OPC_LOAD));
		store_word(5'd5, load_ref[3]);
		// x1 = -7, x2 = 100
		branch_case(3'b000, 5'd1, 5'd1, 1'b1);
		branch_case(3'b000, 5'd1, 5'd2, 1'b0);
		branch_case(3'b001, 5'd1, 5'd2, 1'b1);
		branch_case(3'b001, 5'd1, 5'd1, 1'b0);
		branch_case(3'b100, 5'd1, 5'd2, 1'b1);
		branch_case(3'b100, 5'd2, 5'd1, 1'b0);
		branch_case(3'b101, 5'd2, 5'd1, 1'b1);
		branch_case(3'b101, 5'd1, 5'd2, 1'b0);
		branch_case(3'b110, 5'd2, 5'd1, 1'b1);
		branch_case(3'b110, 5'd1, 5'd2, 1'b0);
		branch_case(3'b111, 5'd1, 5'd2, 1'b1);
		branch_case(3'b111, 5'd2, 5'd1, 1'b0);
		p = cur_pc();
		emit(enc_j(21'd8, 5'd7));
		emit(enc_s(12'h1f0, 5'd0, 5'd0, 3'b010));
		store_word(5'd7, p + 32'd4);
		// jalr to x8 + 13, bit 0 dropped, lands 12 past the auipc
		p = cur_pc();
		emit({20'h0, 5'd8, `RV_OPC_AUIPC});
		emit(enc_i(12'd13, 5'd8, 3'b000, 5'd9, `RV_OPC_JALR));
		emit(enc_s(12'h1f0, 5'd0, 5'd0, 3'b010));
		store_word(5'd9, p + 32'd8);
		emit(32'h0010_0073);
	endtask

	initial begin
		rv_core_pkg::word_t halt_pc;
		rst_n = 1'b0;
		built = 1'b0;
		prog_len = 0;
		store_idx = 0;
		st_addr = 32'h40;
		void'($urandom(32'h7b90));
		for (int i = 0; i < 128; i++) begin
			dmem[i] = $urandom;
		end
		for (int i = 0; i < 4; i++) begin
			load_ref[i] = dmem[i];
		end
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
		end
		build_program();
		// ebreak is the last program word and the pc parks on it
		halt_pc = cur_pc() - 32'd4;
		built = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		forever begin
			@(negedge clk);
			if (halted) begin
				break;
			end
			if (dmem_req.wen) begin
				check_store();
			end
		end
		// a store under the parked pc must stay blocked while halted
		imem[halt_pc[9:2]] = enc_s(12'h1f0, 5'd6, 5'd0, 3'b010);
		repeat (10) begin
			@(negedge clk);
			check_value("halt level", 32'd1, 32'(halted));
			check_value("halt pc", halt_pc, pc);
			check_value("halt wen", 32'd0, 32'(dmem_req.wen));
		end
		assert (store_idx == exp_addr.size()) else begin
			$display("only %0d of %0d stores seen", store_idx, exp_addr.size());
			$display("TESTS FAILED");
			$fatal(1);
		end
		$display("TESTS PASSED");
		$finish;
	end

	// four cycles per program word leaves ample margin
	initial begin
		wait (built);
		repeat (prog_len * 4) @(posedge clk);
		$display("timeout, the core never halted");
		$display("TESTS FAILED");
		$fatal(1);
	end

endmodule

/* hw/rv_core.sv */
// single-cycle RV32I; inst must be the word at pc in the same cycle, no stall input
module rv_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::word_t    inst,
	input  rv_core_pkg::word_t    dmem_rdata,
	output rv_core_pkg::word_t    pc,
	output rv_core_pkg::mem_req_t dmem_req,
	output logic                  halted
);

	rv_core_pkg::decode_t dec;
	rv_core_pkg::reg_idx_t rs1_idx;
	rv_core_pkg::reg_idx_t rs2_idx;
	rv_core_pkg::word_t rs1_data;
	rv_core_pkg::word_t rs2_data;
	rv_core_pkg::word_t alu_result;
	rv_core_pkg::word_t link_addr;
	rv_core_pkg::word_t load_data;
	logic rf_wen;
	rv_core_pkg::reg_idx_t rf_waddr;
	rv_core_pkg::word_t rf_wdata;

	rv_idu u_idu (
		.clk      (clk),
		.rst_n    (rst_n),
		.pc       (pc),
		.inst     (inst),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.dec      (dec)
	);

	rv_regfile u_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rs1_idx),
		.raddr2 (rs2_idx),
		.waddr  (rf_waddr),
		.wen    (rf_wen),
		.wdata  (rf_wdata),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	rv_alu u_alu (
		.dec    (dec),
		.result (alu_result)
	);

	rv_pc_unit u_pc_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec       (dec),
		.pc        (pc),
		.link_addr (link_addr),
		.halted    (halted)
	);

	// alu result doubles as the load/store address
	rv_lsu u_lsu (
		.dec        (dec),
		.addr       (alu_result),
		.halted     (halted),
		.rst_n      (rst_n),
		.dmem_rdata (dmem_rdata),
		.dmem_req   (dmem_req),
		.load_data  (load_data)
	);

	rv_wbu u_wbu (
		.dec        (dec),
		.rst_n      (rst_n),
		.halted     (halted),
		.alu_result (alu_result),
		.load_data  (load_data),
		.link_addr  (link_addr),
		.rf_wen     (rf_wen),
		.rf_waddr   (rf_waddr),
		.rf_wdata   (rf_wdata)
	);

endmodule

/* hw/rv_wbu.sv */
// writes to x0 pass through here and are dropped by the register file
module rv_wbu (
	input  rv_core_pkg::decode_t  dec,
	input  logic                  rst_n,
	input  logic                  halted,
	input  rv_core_pkg::word_t    alu_result,
	input  rv_core_pkg::word_t    load_data,
	input  rv_core_pkg::word_t    link_addr,
	output logic                  rf_wen,
	output rv_core_pkg::reg_idx_t rf_waddr,
	output rv_core_pkg::word_t    rf_wdata
);

	assign rf_waddr = dec.rd;
	assign rf_wen = dec.wb_reg & ~halted & rst_n;

	always_comb begin
		if (|dec.load_kind) begin
			rf_wdata = load_data;
		end else if (dec.jal || dec.jalr) begin
			// return address, not the jump target the alu computed
			rf_wdata = link_addr;
		end else begin
			rf_wdata = alu_result;
		end
	end

endmodule

/* hw/rv_lsu.sv */
// little endian, no misaligned-access checks; the memory reads asynchronously
`include "rv_core_macros.svh"

module rv_lsu (
	input  rv_core_pkg::decode_t  dec,
	input  rv_core_pkg::word_t    addr,
	input  logic                  halted,
	input  logic                  rst_n,
	input  rv_core_pkg::word_t    dmem_rdata,
	output rv_core_pkg::mem_req_t dmem_req,
	output rv_core_pkg::word_t    load_data
);

	logic [1:0] offset;
	logic [4:0] lane_shift;
	rv_core_pkg::strb_t strobe;
	rv_core_pkg::word_t lane_data;

	assign offset = addr[1:0];
	assign lane_shift = {offset, 3'b000};

	// store side
	assign dmem_req.addr = {addr[31:2], 2'b00};
	assign dmem_req.wdata = dec.rs2_val << lane_shift;
	assign dmem_req.wstrb = strobe;
	assign dmem_req.wen = (|dec.store_kind) & ~halted & rst_n;

	always_comb begin
		if (dec.store_kind[0]) begin
			strobe = 4'b1111;
		end else if (dec.store_kind[1]) begin
			strobe = 4'b0011 << {offset[1], 1'b0};
		end else if (dec.store_kind[2]) begin
			strobe = 4'b0001 << offset;
		end else begin
			strobe = 4'b0000;
		end
	end

	// load side, addressed byte moved down to lane 0
	assign lane_data = dmem_rdata >> lane_shift;

	always_comb begin
		if (dec.load_kind[1]) begin
			load_data = {{16{lane_data[15]}}, lane_data[15:0]};
		end else if (dec.load_kind[2]) begin
			load_data = {16'b0, lane_data[15:0]};
		end else if (dec.load_kind[3]) begin
			load_data = {{24{lane_data[7]}}, lane_data[7:0]};
		end else if (dec.load_kind[4]) begin
			load_data = {24'b0, lane_data[7:0]};
		end else begin
			// lw, and don't-care for non-loads
			load_data = dmem_rdata;
		end
	end

endmodule

/* hw/rv_pc_unit.sv */
// no misaligned-target trap; after ebreak the pc stays on the ebreak until reset
`include "rv_core_macros.svh"

module rv_pc_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_core_pkg::decode_t dec,
	output rv_core_pkg::word_t   pc,
	output rv_core_pkg::word_t   link_addr,
	output logic                 halted
);

	rv_core_pkg::word_t next_pc;
	rv_core_pkg::word_t jalr_sum;
	logic eq, lt, ltu, taken;

	assign eq = (dec.rs1_val == dec.rs2_val);
	assign lt = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
	assign ltu = (dec.rs1_val < dec.rs2_val);

	assign taken = (dec.op[`RV_OP_BEQ] & eq) | (dec.op[`RV_OP_BNE] & ~eq) |
		(dec.op[`RV_OP_BLT] & lt) | (dec.op[`RV_OP_BGE] & ~lt) |
		(dec.op[`RV_OP_BLTU] & ltu) | (dec.op[`RV_OP_BGEU] & ~ltu);

	assign link_addr = dec.pc + 32'd4;
	assign jalr_sum = dec.rs1_val + dec.imm;

	always_comb begin
		if (dec.jalr) begin
			next_pc = {jalr_sum[31:1], 1'b0};
		end else if (dec.jal || taken) begin
			next_pc = dec.pc + dec.imm;
		end else begin
			next_pc = link_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			halted <= dec.ebreak;
			if (!dec.ebreak) begin
				pc <= next_pc;
			end
		end
	end

endmodule

/* hw/rv_alu.sv */
// expects a one-hot op; branch bits and an all-zero op give a zero result
`include "rv_core_macros.svh"

module rv_alu (
	input  rv_core_pkg::decode_t dec,
	output rv_core_pkg::word_t   result
);

	rv_core_pkg::word_t a;
	rv_core_pkg::word_t b;
	logic [4:0] shamt;

	assign a = dec.src1;
	assign b = dec.src2;
	// only the low five bits count for RV32 shifts
	assign shamt = b[4:0];

	always_comb begin
		result = '0;
		if (dec.op[`RV_OP_ADD]) begin
			result = a + b;
		end else if (dec.op[`RV_OP_SUB]) begin
			result = a - b;
		end else if (dec.op[`RV_OP_SLT]) begin
			result = {31'b0, $signed(a) < $signed(b)};
		end else if (dec.op[`RV_OP_SLTU]) begin
			result = {31'b0, a < b};
		end else if (dec.op[`RV_OP_AND]) begin
			result = a & b;
		end else if (dec.op[`RV_OP_OR]) begin
			result = a | b;
		end else if (dec.op[`RV_OP_XOR]) begin
			result = a ^ b;
		end else if (dec.op[`RV_OP_SLL]) begin
			result = a << shamt;
		end else if (dec.op[`RV_OP_SRL]) begin
			result = a >> shamt;
		end else if (dec.op[`RV_OP_SRA]) begin
			result = $signed(a) >>> shamt;
		end else if (dec.op[`RV_OP_LUI]) begin
			// src1 is forced to zero, the upper immediate passes straight through
			result = b;
		end
	end

endmodule

/* hw/rv_regfile.sv */
// x0 reads as zero and ignores writes; reads are combinational so write data shows next cycle
`include "rv_core_macros.svh"

module rv_regfile (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::reg_idx_t raddr1,
	input  rv_core_pkg::reg_idx_t raddr2,
	input  rv_core_pkg::reg_idx_t waddr,
	input  logic                  wen,
	input  rv_core_pkg::word_t    wdata,
	output rv_core_pkg::word_t    rdata1,
	output rv_core_pkg::word_t    rdata2
);

	rv_core_pkg::word_t regs [1 << `RV_REG_W];

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << `RV_REG_W); i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

/* hw/rv_idu.sv */
// decodes RV32I only; unknown encodings decode to a no-op, and decode goes quiet after ebreak
`include "rv_core_macros.svh"

module rv_idu (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::word_t    pc,
	input  rv_core_pkg::word_t    inst,
	input  rv_core_pkg::word_t    rs1_data,
	input  rv_core_pkg::word_t    rs2_data,
	output rv_core_pkg::reg_idx_t rs1_idx,
	output rv_core_pkg::reg_idx_t rs2_idx,
	output rv_core_pkg::decode_t  dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_op_imm, is_op, is_load, is_store, is_branch;
	logic f7_base, f7_alt;
	logic inst_addi, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
	logic inst_slli, inst_srli, inst_srai, inst_lui, inst_auipc;
	logic inst_add, inst_sub, inst_slt, inst_sltu, inst_and, inst_or, inst_xor;
	logic inst_sll, inst_srl, inst_sra;
	logic inst_jal, inst_jalr, inst_ebreak;
	logic inst_beq, inst_bne, inst_blt, inst_bltu, inst_bge, inst_bgeu;
	logic inst_lw, inst_lh, inst_lhu, inst_lb, inst_lbu;
	logic inst_sw, inst_sh, inst_sb;
	rv_core_pkg::word_t imm_i, imm_u, imm_j, imm_s, imm_b;
	logic imm_is_i, imm_is_u, imm_is_j, imm_is_s, imm_is_b;
	logic src1_from_pc, src1_is_zero, src2_from_imm;
	rv_core_pkg::word_t imm;
	rv_core_pkg::alu_op_t op;
	logic stopped;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];

	assign is_op_imm = (opcode == `RV_OPC_OP_IMM);
	assign is_op = (opcode == `RV_OPC_OP);
	assign is_load = (opcode == `RV_OPC_LOAD);
	assign is_store = (opcode == `RV_OPC_STORE);
	assign is_branch = (opcode == `RV_OPC_BRANCH);
	assign f7_base = (funct7 == 7'b000_0000);
	assign f7_alt = (funct7 == 7'b010_0000);

	// register-immediate
	assign inst_addi = is_op_imm && (funct3 == 3'b000);
	assign inst_slli = is_op_imm && (funct3 == 3'b001) && f7_base;
	assign inst_slti = is_op_imm && (funct3 == 3'b010);
	assign inst_sltiu = is_op_imm && (funct3 == 3'b011);
	assign inst_xori = is_op_imm && (funct3 == 3'b100);
	assign inst_srli = is_op_imm && (funct3 == 3'b101) && f7_base;
	assign inst_srai = is_op_imm && (funct3 == 3'b101) && f7_alt;
	assign inst_ori = is_op_imm && (funct3 == 3'b110);
	assign inst_andi = is_op_imm && (funct3 == 3'b111);
	assign inst_lui = (opcode == `RV_OPC_LUI);
	assign inst_auipc = (opcode == `RV_OPC_AUIPC);

	// register-register
	assign inst_add = is_op && (funct3 == 3'b000) && f7_base;
	assign inst_sub = is_op && (funct3 == 3'b000) && f7_alt;
	assign inst_sll = is_op && (funct3 == 3'b001) && f7_base;
	assign inst_slt = is_op && (funct3 == 3'b010) && f7_base;
	assign inst_sltu = is_op && (funct3 == 3'b011) && f7_base;
	assign inst_xor = is_op && (funct3 == 3'b100) && f7_base;
	assign inst_srl = is_op && (funct3 == 3'b101) && f7_base;
	assign inst_sra = is_op && (funct3 == 3'b101) && f7_alt;
	assign inst_or = is_op && (funct3 == 3'b110) && f7_base;
	assign inst_and = is_op && (funct3 == 3'b111) && f7_base;

	assign inst_jal = (opcode == `RV_OPC_JAL);
	assign inst_jalr = (opcode == `RV_OPC_JALR) && (funct3 == 3'b000);
	// imm 1, rs1 x0, funct3 0, rd x0
	assign inst_ebreak = (opcode == `RV_OPC_SYSTEM) && (inst[31:7] == {12'h001, 13'h0});

	assign inst_beq = is_branch && (funct3 == 3'b000);
	assign inst_bne = is_branch && (funct3 == 3'b001);
	assign inst_blt = is_branch && (funct3 == 3'b100);
	assign inst_bge = is_branch && (funct3 == 3'b101);
	assign inst_bltu = is_branch && (funct3 == 3'b110);
	assign inst_bgeu = is_branch && (funct3 == 3'b111);

	assign inst_lb = is_load && (funct3 == 3'b000);
	assign inst_lh = is_load && (funct3 == 3'b001);
	assign inst_lw = is_load && (funct3 == 3'b010);
	assign inst_lbu = is_load && (funct3 == 3'b100);
	assign inst_lhu = is_load && (funct3 == 3'b101);
	assign inst_sb = is_store && (funct3 == 3'b000);
	assign inst_sh = is_store && (funct3 == 3'b001);
	assign inst_sw = is_store && (funct3 == 3'b010);

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	assign imm_is_i = is_op_imm | inst_jalr | is_load;
	assign imm_is_u = inst_lui | inst_auipc;
	assign imm_is_j = inst_jal;
	assign imm_is_s = is_store;
	assign imm_is_b = is_branch;

	assign imm = ({32{imm_is_i}} & imm_i) |
		({32{imm_is_u}} & imm_u) |
		({32{imm_is_j}} & imm_j) |
		({32{imm_is_s}} & imm_s) |
		({32{imm_is_b}} & imm_b);

	// branches compare registers, so their immediate stays off src2
	assign src2_from_imm = imm_is_i | imm_is_u | imm_is_j | imm_is_s;
	assign src1_from_pc = inst_jal | inst_auipc;
	assign src1_is_zero = inst_lui;

	assign op[`RV_OP_ADD] = inst_addi | inst_add | inst_auipc | inst_jal | inst_jalr |
		is_load | is_store;
	assign op[`RV_OP_SUB] = inst_sub;
	assign op[`RV_OP_SLT] = inst_slti | inst_slt;
	assign op[`RV_OP_SLTU] = inst_sltiu | inst_sltu;
	assign op[`RV_OP_AND] = inst_andi | inst_and;
	assign op[`RV_OP_OR] = inst_ori | inst_or;
	assign op[`RV_OP_XOR] = inst_xori | inst_xor;
	assign op[`RV_OP_SLL] = inst_slli | inst_sll;
	assign op[`RV_OP_SRL] = inst_srli | inst_srl;
	assign op[`RV_OP_SRA] = inst_srai | inst_sra;
	assign op[`RV_OP_LUI] = inst_lui;
	assign op[`RV_OP_BEQ] = inst_beq & ~stopped;
	assign op[`RV_OP_BNE] = inst_bne & ~stopped;
	assign op[`RV_OP_BLT] = inst_blt & ~stopped;
	assign op[`RV_OP_BLTU] = inst_bltu & ~stopped;
	assign op[`RV_OP_BGE] = inst_bge & ~stopped;
	assign op[`RV_OP_BGEU] = inst_bgeu & ~stopped;

	// once ebreak retires the decoder only issues bubbles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stopped <= 1'b0;
		end else if (inst_ebreak) begin
			stopped <= 1'b1;
		end
	end

	always_comb begin
		dec.pc = pc;
		dec.src1 = src1_from_pc ? pc : (src1_is_zero ? '0 : rs1_data);
		dec.src2 = src2_from_imm ? imm : rs2_data;
		dec.op = op;
		dec.rs1_val = rs1_data;
		dec.rs2_val = rs2_data;
		dec.imm = imm;
		dec.rd = inst[11:7];
		dec.wb_reg = ~stopped & (is_op_imm | is_op | imm_is_u | inst_jal | inst_jalr | is_load);
		dec.load_kind = {inst_lbu, inst_lb, inst_lhu, inst_lh, inst_lw} & {5{~stopped}};
		dec.store_kind = {inst_sb, inst_sh, inst_sw} & {3{~stopped}};
		dec.jal = inst_jal & ~stopped;
		dec.jalr = inst_jalr & ~stopped;
		dec.ebreak = inst_ebreak & ~stopped;
	end

endmodule

/* hw/rv_core_pkg.sv */
// shared core types; load and store kinds are one-hot, all zero means no memory access
`include "rv_core_macros.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_W-1:0] reg_idx_t;
	typedef logic [`RV_OP_W-1:0] alu_op_t;

	// bit 0 lw, 1 lh, 2 lhu, 3 lb, 4 lbu
	typedef logic [4:0] load_kind_t;

	// bit 0 sw, 1 sh, 2 sb
	typedef logic [2:0] store_kind_t;

	// one bit per byte lane
	typedef logic [`RV_XLEN/8-1:0] strb_t;

	typedef struct packed {
		word_t       pc;
		// alu operands after source selection
		word_t       src1;
		word_t       src2;
		alu_op_t     op;
		// raw register values, for branch compare, jalr and store data
		word_t       rs1_val;
		word_t       rs2_val;
		word_t       imm;
		reg_idx_t    rd;
		logic        wb_reg;
		load_kind_t  load_kind;
		store_kind_t store_kind;
		logic        jal;
		logic        jalr;
		logic        ebreak;
	} decode_t;

	typedef struct packed {
		// word aligned
		word_t addr;
		word_t wdata;
		strb_t wstrb;
		logic  wen;
	} mem_req_t;

endpackage

/* hw/rv_core_macros.svh */
// RV32I base encodings only; no compressed, CSR or fence opcodes are defined here
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

`define RV_XLEN     32
`define RV_REG_W    5
`define RV_OP_W     17
`define RV_RESET_PC 32'h0000_0000

// major opcodes
`define RV_OPC_OP_IMM 7'b001_0011
`define RV_OPC_OP     7'b011_0011
`define RV_OPC_LUI    7'b011_0111
`define RV_OPC_AUIPC  7'b001_0111
`define RV_OPC_JAL    7'b110_1111
`define RV_OPC_JALR   7'b110_0111
`define RV_OPC_BRANCH 7'b110_0011
`define RV_OPC_LOAD   7'b000_0011
`define RV_OPC_STORE  7'b010_0011
`define RV_OPC_SYSTEM 7'b111_0011

// bit positions in the one-hot alu op
`define RV_OP_ADD  0
`define RV_OP_SUB  1
`define RV_OP_SLT  2
`define RV_OP_SLTU 3
`define RV_OP_AND  4
`define RV_OP_OR   5
`define RV_OP_XOR  6
`define RV_OP_SLL  7
`define RV_OP_SRL  8
`define RV_OP_SRA  9
`define RV_OP_LUI  10
`define RV_OP_BEQ  11
`define RV_OP_BNE  12
`define RV_OP_BLT  13
`define RV_OP_BLTU 14
`define RV_OP_BGE  15
`define RV_OP_BGEU 16

`endif
